// ==== flist.f ====
hdl/frontend_cfg_pkg.sv
hdl/frontend_types_pkg.sv
hdl/fetch_if.sv
hdl/branch_predictor.sv
hdl/icache.sv
hdl/ifu.sv
hdl/frontend.sv
testbench/tb_frontend.sv

// ==== hdl/branch_predictor.sv ====
// branch target buffer
`timescale 1ns/1ps

module branch_predictor
  import frontend_cfg_pkg::*;
  import frontend_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  addr_t                       lookup_pc_i,
  output slot_mask_t                  taken_o,
  output addr_t [INSTR_PER_FETCH-1:0] target_o,
  input  logic                        update_valid_i,
  input  logic                        update_taken_i,
  input  addr_t                       update_pc_i,
  input  addr_t                       update_target_i
);

  logic [BTB_ENTRIES-1:0] btb_valid_q;
  btb_tag_t               btb_tag_q    [BTB_ENTRIES];
  addr_t                  btb_target_q [BTB_ENTRIES];

  addr_t      block_base;
  btb_index_t upd_idx;

  assign block_base = lookup_pc_i & ~addr_t'(FETCH_BYTES - 1);
  assign upd_idx    = update_pc_i[BTB_INDEX_BITS+INSTR_OFFSET_BITS-1:INSTR_OFFSET_BITS];

  // ==========================================================
  // per slot lookup
  // ==========================================================
  for (genvar s = 0; s < INSTR_PER_FETCH; s++) begin : g_slot
    addr_t      slot_pc;
    btb_index_t slot_idx;
    btb_tag_t   slot_tag;

    assign slot_pc  = block_base + addr_t'(s * INSTR_BYTES);
    assign slot_idx = slot_pc[BTB_INDEX_BITS+INSTR_OFFSET_BITS-1:INSTR_OFFSET_BITS];
    assign slot_tag = slot_pc[PLEN-1:BTB_INDEX_BITS+INSTR_OFFSET_BITS];

    assign taken_o[s]  = btb_valid_q[slot_idx] && (btb_tag_q[slot_idx] == slot_tag);
    assign target_o[s] = btb_target_q[slot_idx];
  end

  // ==========================================================
  // table update
  // ==========================================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      btb_valid_q <= '0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_tag_q[i]    <= '0;
        btb_target_q[i] <= '0;
      end
    end else if (update_valid_i) begin
      // not taken simply drops the entry
      btb_valid_q[upd_idx] <= update_taken_i;
      if (update_taken_i) begin
        btb_tag_q[upd_idx]    <= update_pc_i[PLEN-1:BTB_INDEX_BITS+INSTR_OFFSET_BITS];
        btb_target_q[upd_idx] <= update_target_i;
      end
    end
  end

endmodule

// ==== hdl/fetch_if.sv ====
// fetch request channel
`timescale 1ns/1ps

interface fetch_if
  import frontend_types_pkg::*;
  ();

  // request side, block aligned address
  logic         req_valid;
  logic         req_ready;
  addr_t        req_addr;

  // single cycle response, always taken
  logic         rsp_valid;
  fetch_block_t rsp_data;

  modport ifu (
    output req_valid, req_addr,
    input  req_ready, rsp_valid, rsp_data
  );

  modport icache (
    input  req_valid, req_addr,
    output req_ready, rsp_valid, rsp_data
  );

endinterface

// ==== hdl/frontend.sv ====
// instruction fetch front end
`timescale 1ns/1ps

module frontend
  import frontend_cfg_pkg::*;
  import frontend_types_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // ==========================================================
  // backend buffer
  // ==========================================================
  output logic                            ibuffer_valid_o,
  input  logic                            ibuffer_ready_i,
  output logic [FETCH_BITS-1:0]           ibuffer_data_o,
  output addr_t                           ibuffer_pc_o,
  output slot_mask_t                      ibuffer_slot_valid_o,
  output logic [INSTR_PER_FETCH*PLEN-1:0] ibuffer_pred_npc_o,

  // redirect and predictor training
  input  logic                            flush_i,
  input  addr_t                           redirect_pc_i,
  input  logic                            bpu_update_valid_i,
  input  addr_t                           bpu_update_pc_i,
  input  logic                            bpu_update_taken_i,
  input  addr_t                           bpu_update_target_i,

  // ==========================================================
  // memory side
  // ==========================================================
  output logic                            miss_req_valid_o,
  input  logic                            miss_req_ready_i,
  output addr_t                           miss_req_paddr_o,
  output cache_index_t                    miss_req_index_o,
  input  logic                            refill_valid_i,
  output logic                            refill_ready_o,
  input  addr_t                           refill_paddr_i,
  input  cache_line_t                     refill_data_i
);

  addr_t                       bp_pc;
  slot_mask_t                  bp_taken;
  addr_t [INSTR_PER_FETCH-1:0] bp_target;

  fetch_if fetch_bus ();

  ifu i_ifu (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .fetch             (fetch_bus.ifu),
    .flush_i           (flush_i),
    .redirect_pc_i     (redirect_pc_i),
    .bp_pc_o           (bp_pc),
    .bp_taken_i        (bp_taken),
    .bp_target_i       (bp_target),
    .ibuf_valid_o      (ibuffer_valid_o),
    .ibuf_ready_i      (ibuffer_ready_i),
    .ibuf_data_o       (ibuffer_data_o),
    .ibuf_pc_o         (ibuffer_pc_o),
    .ibuf_slot_valid_o (ibuffer_slot_valid_o),
    .ibuf_pred_npc_o   (ibuffer_pred_npc_o)
  );

  icache i_icache (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .fetch            (fetch_bus.icache),
    .miss_req_valid_o (miss_req_valid_o),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_req_paddr_o (miss_req_paddr_o),
    .miss_req_index_o (miss_req_index_o),
    .refill_valid_i   (refill_valid_i),
    .refill_ready_o   (refill_ready_o),
    .refill_paddr_i   (refill_paddr_i),
    .refill_data_i    (refill_data_i)
  );

  branch_predictor i_bpu (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .lookup_pc_i     (bp_pc),
    .taken_o         (bp_taken),
    .target_o        (bp_target),
    .update_valid_i  (bpu_update_valid_i),
    .update_taken_i  (bpu_update_taken_i),
    .update_pc_i     (bpu_update_pc_i),
    .update_target_i (bpu_update_target_i)
  );

endmodule

// ==== hdl/frontend_cfg_pkg.sv ====
// front end configuration
package frontend_cfg_pkg;

  // ==========================================================
  // base sizes
  // ==========================================================
  localparam int PLEN            = 32;
  localparam int ILEN            = 32;
  localparam int INSTR_PER_FETCH = 2;
  localparam int LINE_BYTES      = 16;
  localparam int ICACHE_SETS     = 16;
  localparam int BTB_ENTRIES     = 16;

  localparam logic [PLEN-1:0] RESET_PC = 32'h0000_1000;

  // ==========================================================
  // derived widths
  // ==========================================================
  localparam int INSTR_BYTES       = ILEN / 8;
  localparam int FETCH_BITS        = INSTR_PER_FETCH * ILEN;
  localparam int FETCH_BYTES       = FETCH_BITS / 8;
  localparam int LINE_BITS         = LINE_BYTES * 8;
  localparam int INSTR_OFFSET_BITS = $clog2(INSTR_BYTES);
  localparam int FETCH_OFFSET_BITS = $clog2(FETCH_BYTES);
  localparam int OFFSET_BITS       = $clog2(LINE_BYTES);
  localparam int INDEX_BITS        = $clog2(ICACHE_SETS);
  localparam int TAG_BITS          = PLEN - INDEX_BITS - OFFSET_BITS;

  // btb is indexed by word address
  localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_BITS   = PLEN - BTB_INDEX_BITS - INSTR_OFFSET_BITS;

endpackage

// ==== hdl/frontend_types_pkg.sv ====
// front end types
package frontend_types_pkg;

  import frontend_cfg_pkg::*;

  // ==========================================================
  // addresses and payload
  // ==========================================================
  typedef logic [PLEN-1:0]        addr_t;
  typedef logic [ILEN-1:0]        instr_t;
  // slot 0 sits in the low bits
  typedef logic [FETCH_BITS-1:0]  fetch_block_t;
  typedef logic [LINE_BITS-1:0]   cache_line_t;
  typedef logic [INSTR_PER_FETCH-1:0] slot_mask_t;

  // ==========================================================
  // cache and btb address fields
  // ==========================================================
  typedef logic [INDEX_BITS-1:0]     cache_index_t;
  typedef logic [TAG_BITS-1:0]       cache_tag_t;
  typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
  typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;

  // instruction cache controller
  typedef enum logic [1:0] {
    IDLE,
    MISS_REQ,
    REFILL_WAIT
  } icache_state_e;

endpackage

// ==== hdl/icache.sv ====
// direct mapped instruction cache
`timescale 1ns/1ps

module icache
  import frontend_cfg_pkg::*;
  import frontend_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  fetch_if.icache      fetch,
  output logic         miss_req_valid_o,
  input  logic         miss_req_ready_i,
  output addr_t        miss_req_paddr_o,
  output cache_index_t miss_req_index_o,
  input  logic         refill_valid_i,
  output logic         refill_ready_o,
  input  addr_t        refill_paddr_i,
  input  cache_line_t  refill_data_i
);

  icache_state_e state_q;

  logic [ICACHE_SETS-1:0] valid_q;
  cache_tag_t             tag_q  [ICACHE_SETS];
  cache_line_t            data_q [ICACHE_SETS];

  // replay_q answers the missed request once its line is in
  logic         replay_q;
  logic         rsp_valid_q;
  fetch_block_t rsp_data_q;
  addr_t        req_addr_q;

  addr_t        lk_addr;
  cache_index_t lk_idx;
  cache_tag_t   lk_tag;
  logic [OFFSET_BITS-FETCH_OFFSET_BITS-1:0] lk_blk;
  logic         lk_hit;
  fetch_block_t lk_data;
  logic         req_fire;
  logic         refill_fire;
  cache_index_t ref_idx;

  // ==========================================================
  // lookup
  // ==========================================================
  assign lk_addr = replay_q ? req_addr_q : fetch.req_addr;
  assign lk_idx  = lk_addr[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
  assign lk_tag  = lk_addr[PLEN-1:OFFSET_BITS+INDEX_BITS];
  assign lk_blk  = lk_addr[OFFSET_BITS-1:FETCH_OFFSET_BITS];
  assign lk_hit  = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign lk_data = data_q[lk_idx][lk_blk*FETCH_BITS +: FETCH_BITS];

  assign fetch.req_ready = (state_q == IDLE) && !replay_q;
  assign fetch.rsp_valid = rsp_valid_q;
  assign fetch.rsp_data  = rsp_data_q;

  assign req_fire    = fetch.req_valid && fetch.req_ready;
  assign refill_fire = refill_valid_i && refill_ready_o;
  assign ref_idx     = refill_paddr_i[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];

  // miss channel, line aligned
  assign miss_req_valid_o = (state_q == MISS_REQ);
  assign miss_req_paddr_o = {req_addr_q[PLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign miss_req_index_o = req_addr_q[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
  assign refill_ready_o   = (state_q == REFILL_WAIT);

  // ==========================================================
  // control
  // ==========================================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      replay_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
      valid_q     <= '0;
    end else begin
      rsp_valid_q <= (req_fire && lk_hit) || replay_q;
      replay_q    <= refill_fire;
      if (refill_fire) begin
        valid_q[ref_idx] <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (req_fire && !lk_hit) begin
            state_q <= MISS_REQ;
          end
        end
        MISS_REQ: begin
          if (miss_req_ready_i) begin
            state_q <= REFILL_WAIT;
          end
        end
        REFILL_WAIT: begin
          if (refill_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // arrays and response data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_addr_q <= fetch.req_addr;
    end
    if (req_fire || replay_q) begin
      rsp_data_q <= lk_data;
    end
    if (refill_fire) begin
      tag_q[ref_idx]  <= refill_paddr_i[PLEN-1:OFFSET_BITS+INDEX_BITS];
      data_q[ref_idx] <= refill_data_i;
    end
  end

endmodule

// ==== hdl/ifu.sv ====
// instruction fetch unit
`timescale 1ns/1ps

module ifu
  import frontend_cfg_pkg::*;
  import frontend_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  fetch_if.ifu                        fetch,
  input  logic                        flush_i,
  input  addr_t                       redirect_pc_i,
  output addr_t                       bp_pc_o,
  input  slot_mask_t                  bp_taken_i,
  input  addr_t [INSTR_PER_FETCH-1:0] bp_target_i,
  output logic                        ibuf_valid_o,
  input  logic                        ibuf_ready_i,
  output fetch_block_t                ibuf_data_o,
  output addr_t                       ibuf_pc_o,
  output slot_mask_t                  ibuf_slot_valid_o,
  output addr_t [INSTR_PER_FETCH-1:0] ibuf_pred_npc_o
);

  addr_t pc_q;
  logic  inflight_q;
  addr_t inflight_pc_q;
  logic  stale_q;
  logic  ibuf_valid_q;

  logic  req_fire;
  logic  rsp_take;
  addr_t blk_base;
  logic [FETCH_OFFSET_BITS-INSTR_OFFSET_BITS-1:0] word_off;

  slot_mask_t                  blk_mask;
  addr_t [INSTR_PER_FETCH-1:0] blk_npc;
  addr_t                       blk_next_pc;

  // ==========================================================
  // request side
  // ==========================================================
  // one request at a time, and only if the output slot will be free
  assign fetch.req_valid = !inflight_q && !flush_i && (!ibuf_valid_q || ibuf_ready_i);
  assign fetch.req_addr  = pc_q & ~addr_t'(FETCH_BYTES - 1);

  assign req_fire = fetch.req_valid && fetch.req_ready;
  assign rsp_take = fetch.rsp_valid && !stale_q && !flush_i;
  assign bp_pc_o  = inflight_pc_q;

  // ==========================================================
  // fetch block rule
  // ==========================================================
  assign blk_base = inflight_pc_q & ~addr_t'(FETCH_BYTES - 1);
  assign word_off = inflight_pc_q[FETCH_OFFSET_BITS-1:INSTR_OFFSET_BITS];

  always_comb begin : blk_rule
    logic cut;
    cut         = 1'b0;
    blk_mask    = '0;
    blk_npc     = '0;
    blk_next_pc = '0;
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      // slots before the fetch pc and after a taken slot stay empty
      if (!cut && (s >= int'(word_off))) begin
        blk_mask[s] = 1'b1;
        if (bp_taken_i[s]) begin
          blk_npc[s] = bp_target_i[s];
        end else begin
          blk_npc[s] = blk_base + addr_t'((s + 1) * INSTR_BYTES);
        end
        blk_next_pc = blk_npc[s];
        cut         = bp_taken_i[s];
      end
    end
  end

  // ==========================================================
  // control
  // ==========================================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q         <= RESET_PC;
      inflight_q   <= 1'b0;
      stale_q      <= 1'b0;
      ibuf_valid_q <= 1'b0;
    end else begin
      if (req_fire) begin
        inflight_q <= 1'b1;
      end else if (fetch.rsp_valid) begin
        inflight_q <= 1'b0;
      end

      // a response landing with the flush is dropped right away
      if (flush_i) begin
        stale_q <= inflight_q && !fetch.rsp_valid;
      end else if (fetch.rsp_valid) begin
        stale_q <= 1'b0;
      end

      if (flush_i) begin
        pc_q <= redirect_pc_i;
      end else if (rsp_take) begin
        pc_q <= blk_next_pc;
      end

      if (flush_i) begin
        ibuf_valid_q <= 1'b0;
      end else if (rsp_take) begin
        ibuf_valid_q <= 1'b1;
      end else if (ibuf_ready_i) begin
        ibuf_valid_q <= 1'b0;
      end
    end
  end

  // request pc and output payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      inflight_pc_q <= pc_q;
    end
    if (rsp_take) begin
      ibuf_data_o       <= fetch.rsp_data;
      ibuf_pc_o         <= inflight_pc_q;
      ibuf_slot_valid_o <= blk_mask;
      ibuf_pred_npc_o   <= blk_npc;
    end
  end

  assign ibuf_valid_o = ibuf_valid_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_frontend \
  -f flist.f -o tb_frontend
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

out=$(./obj_dir/tb_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== testbench/tb_frontend.sv ====
// front end testbench
`timescale 1ns/1ps

module tb_frontend
  import frontend_cfg_pkg::*;
  import frontend_types_pkg::*;
();

  logic                            clk_i;
  logic                            arst_n_i;
  logic                            ibuffer_valid_o;
  logic                            ibuffer_ready_i;
  logic [FETCH_BITS-1:0]           ibuffer_data_o;
  addr_t                           ibuffer_pc_o;
  slot_mask_t                      ibuffer_slot_valid_o;
  logic [INSTR_PER_FETCH*PLEN-1:0] ibuffer_pred_npc_o;
  logic                            flush_i;
  addr_t                           redirect_pc_i;
  logic                            bpu_update_valid_i;
  addr_t                           bpu_update_pc_i;
  logic                            bpu_update_taken_i;
  addr_t                           bpu_update_target_i;
  logic                            miss_req_valid_o;
  logic                            miss_req_ready_i;
  addr_t                           miss_req_paddr_o;
  cache_index_t                    miss_req_index_o;
  logic                            refill_valid_i;
  logic                            refill_ready_o;
  addr_t                           refill_paddr_i;
  cache_line_t                     refill_data_i;

  int errors;
  int checks;
  int timeouts;
  int misses;
  int beat_count;

  // model btb and expected fetch pc
  logic     model_valid  [BTB_ENTRIES];
  btb_tag_t model_tag    [BTB_ENTRIES];
  addr_t    model_target [BTB_ENTRIES];
  addr_t    exp_pc;

  // memory side
  icache_state_e mem_phase;
  addr_t         pend_paddr;
  int            delay;
  int            refill_wait;
  cache_tag_t    seen_tag [cache_index_t];

  frontend DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ==========================================================
  // memory model and reference
  // ==========================================================
  function automatic instr_t mem_word(input addr_t a);
    return instr_t'(a ^ 32'hA5A5_0000);
  endfunction

  function automatic cache_line_t mem_line(input addr_t base);
    cache_line_t line;
    for (int k = 0; k < LINE_BYTES / 4; k++) begin
      line[k*ILEN +: ILEN] = mem_word(base + addr_t'(4 * k));
    end
    return line;
  endfunction

  function automatic void train_btb(input addr_t pc, input logic taken, input addr_t target);
    btb_index_t idx;
    idx = pc[5:2];
    model_valid[idx] = taken;
    if (taken) begin
      model_tag[idx]    = pc[31:6];
      model_target[idx] = target;
    end
  endfunction

  function automatic void ref_block(input addr_t pc, output fetch_block_t data,
                                    output slot_mask_t mask,
                                    output addr_t [INSTR_PER_FETCH-1:0] npc,
                                    output addr_t next_pc);
    addr_t      base;
    addr_t      slot_pc;
    btb_index_t idx;
    logic       hit;
    logic       cut;
    base    = {pc[PLEN-1:3], 3'b000};
    cut     = 1'b0;
    mask    = '0;
    npc     = '0;
    next_pc = '0;
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      slot_pc             = base + addr_t'(4 * s);
      data[s*ILEN +: ILEN] = mem_word(slot_pc);
      idx                 = slot_pc[5:2];
      hit                 = model_valid[idx] && (model_tag[idx] == slot_pc[31:6]);
      // word 0 is skipped when the pc points at word 1
      if (!cut && !(s == 0 && pc[2])) begin
        mask[s] = 1'b1;
        npc[s]  = hit ? model_target[idx] : slot_pc + 32'd4;
        next_pc = npc[s];
        cut     = hit;
      end
    end
  endfunction

  // ==========================================================
  // compare tasks
  // ==========================================================
  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_block(input string what, input fetch_block_t got,
                             input fetch_block_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input string what, input slot_mask_t got, input slot_mask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_index(input string what, input cache_index_t got,
                             input cache_index_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic log_miss(input addr_t paddr, input cache_index_t idx);
    cache_index_t set;
    cache_tag_t   tag;
    set = paddr[7:4];
    tag = paddr[31:8];
    check_addr("miss paddr", paddr, {paddr[31:4], 4'h0});
    check_index("miss index", idx, set);
    // the lines used here all fit the cache and are never evicted
    if (seen_tag.exists(set) && seen_tag[set] == tag) begin
      errors++;
      $display("line %h was requested from memory a second time", paddr);
    end
    seen_tag[set] = tag;
    misses++;
  endtask

  // ==========================================================
  // memory responder
  // ==========================================================
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      mem_phase   = IDLE;
      delay       = 0;
      refill_wait = 0;
    end else begin
      miss_req_ready_i <= ($urandom % 3) != 0;
      case (mem_phase)
        IDLE: begin
          if (miss_req_valid_o && miss_req_ready_i) begin
            log_miss(miss_req_paddr_o, miss_req_index_o);
            pend_paddr  = miss_req_paddr_o;
            delay       = 1 + int'($urandom % 6);
            refill_wait = 0;
            mem_phase   = REFILL_WAIT;
          end
        end
        default: begin
          if (refill_valid_i && refill_ready_o) begin
            refill_valid_i <= 1'b0;
            mem_phase = IDLE;
          end else if (!refill_valid_i) begin
            delay = delay - 1;
            if (delay == 0) begin
              refill_valid_i <= 1'b1;
              refill_paddr_i <= pend_paddr;
              refill_data_i  <= mem_line(pend_paddr);
            end
          end else begin
            refill_wait++;
            if (refill_wait >= 200) begin
              $display("refill of line %h was never accepted by the cache", pend_paddr);
              timeouts++;
              refill_valid_i <= 1'b0;
              mem_phase = IDLE;
            end
          end
        end
      endcase
    end
  end

  // backend stalls at random
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      ibuffer_ready_i <= ($urandom % 4) != 0;
    end
  end

  // ==========================================================
  // compare process
  // ==========================================================
  always @(posedge clk_i) begin : compare_beats
    fetch_block_t                e_data;
    slot_mask_t                  e_mask;
    addr_t [INSTR_PER_FETCH-1:0] e_npc;
    addr_t                       e_next;
    logic                        held;
    fetch_block_t                held_data;
    addr_t                       held_pc;
    slot_mask_t                  held_mask;
    addr_t [INSTR_PER_FETCH-1:0] held_npc;
    if (!arst_n_i) begin
      held   = 1'b0;
      exp_pc = RESET_PC;
    end else if (flush_i) begin
      // a block still in the output register is thrown away
      held   = 1'b0;
      exp_pc = redirect_pc_i;
      if (bpu_update_valid_i) begin
        train_btb(bpu_update_pc_i, bpu_update_taken_i, bpu_update_target_i);
      end
    end else begin
      if (held) begin
        if (!ibuffer_valid_o) begin
          errors++;
          $display("ibuffer valid dropped at %0t while the backend stalled", $time);
        end
        check_addr("stalled pc", ibuffer_pc_o, held_pc);
        check_block("stalled data", ibuffer_data_o, held_data);
        check_mask("stalled slot mask", ibuffer_slot_valid_o, held_mask);
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          check_addr("stalled pred npc", ibuffer_pred_npc_o[s*PLEN +: PLEN], held_npc[s]);
        end
      end
      if (ibuffer_valid_o && ibuffer_ready_i) begin
        ref_block(exp_pc, e_data, e_mask, e_npc, e_next);
        check_addr("block pc", ibuffer_pc_o, exp_pc);
        check_block("block data", ibuffer_data_o, e_data);
        check_mask("slot mask", ibuffer_slot_valid_o, e_mask);
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          check_addr("pred npc", ibuffer_pred_npc_o[s*PLEN +: PLEN], e_npc[s]);
        end
        exp_pc = e_next;
        beat_count <= beat_count + 1;
      end
      held      = ibuffer_valid_o && !ibuffer_ready_i;
      held_pc   = ibuffer_pc_o;
      held_data = ibuffer_data_o;
      held_mask = ibuffer_slot_valid_o;
      held_npc  = ibuffer_pred_npc_o;
    end
  end

  // ==========================================================
  // stimulus
  // ==========================================================
  task automatic wait_one_beat();
    int target;
    int cycles;
    target = beat_count + 1;
    cycles = 0;
    while (timeouts == 0 && beat_count < target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= 200) begin
        $display("no block reached the backend within 200 cycles");
        timeouts++;
      end
    end
  endtask

  task automatic wait_beats(input int n);
    repeat (n) wait_one_beat();
  endtask

  task automatic wait_miss_pending();
    int cycles;
    cycles = 0;
    while (timeouts == 0 && !(miss_req_valid_o || refill_ready_o)) begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= 200) begin
        $display("the cache never started a miss within 200 cycles");
        timeouts++;
      end
    end
  endtask

  // one cycle flush that can also train the btb on the same edge
  task automatic redirect_fetch(input addr_t pc, input logic train, input addr_t upd_pc,
                                input logic taken, input addr_t target);
    @(posedge clk_i);
    flush_i             <= 1'b1;
    redirect_pc_i       <= pc;
    bpu_update_valid_i  <= train;
    bpu_update_pc_i     <= upd_pc;
    bpu_update_taken_i  <= taken;
    bpu_update_target_i <= target;
    @(posedge clk_i);
    flush_i            <= 1'b0;
    bpu_update_valid_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(30));
    errors              = 0;
    checks              = 0;
    timeouts            = 0;
    misses              = 0;
    beat_count          = 0;
    arst_n_i            = 1'b0;
    ibuffer_ready_i     = 1'b0;
    flush_i             = 1'b0;
    redirect_pc_i       = '0;
    bpu_update_valid_i  = 1'b0;
    bpu_update_pc_i     = '0;
    bpu_update_taken_i  = 1'b0;
    bpu_update_target_i = '0;
    miss_req_ready_i    = 1'b0;
    refill_valid_i      = 1'b0;
    refill_paddr_i      = '0;
    refill_data_i       = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      model_valid[i]  = 1'b0;
      model_tag[i]    = '0;
      model_target[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // sequential fetch from reset and a second pass over the same lines
    wait_beats(10);
    redirect_fetch(RESET_PC, 1'b0, '0, 1'b0, '0);
    wait_beats(6);

    // taken slot 1 to a misaligned target
    redirect_fetch(32'h0000_1010, 1'b1, 32'h0000_1014, 1'b1, 32'h0000_1034);
    wait_beats(4);
    // taken slot 0 loops back
    redirect_fetch(32'h0000_1038, 1'b1, 32'h0000_1040, 1'b1, 32'h0000_1020);
    wait_beats(8);
    // not taken updates restore sequential fetch
    redirect_fetch(32'h0000_1038, 1'b1, 32'h0000_1040, 1'b0, '0);
    wait_beats(4);
    redirect_fetch(32'h0000_1010, 1'b1, 32'h0000_1014, 1'b0, '0);
    wait_beats(3);

    // flush while a miss is pending
    redirect_fetch(32'h0000_1080, 1'b0, '0, 1'b0, '0);
    wait_miss_pending();
    redirect_fetch(32'h0000_1008, 1'b0, '0, 1'b0, '0);
    wait_beats(3);
    // flush while a hit is in flight
    redirect_fetch(RESET_PC, 1'b0, '0, 1'b0, '0);
    redirect_fetch(32'h0000_1020, 1'b0, '0, 1'b0, '0);
    wait_beats(3);

    repeat (10) @(posedge clk_i);
    $display("blocks %0d, misses %0d, checks %0d, errors %0d, timeouts %0d",
             beat_count, misses, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
